/* sim.f */
source/icache_pkg.sv
source/icache_data_ram.sv
source/icache_tag_ram.sv
source/icache_way.sv
source/icache_array.sv
source/icache_top.sv
tests/icache_asserts.sv
tests/icache_tb.sv

/* Makefile */
SIM := obj_dir/Vicache_tb
SRCS := $(wildcard source/*.sv tests/*.sv)

.PHONY: run clean

run: $(SIM)
	$(SIM) +verilator+error+limit+100 | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "no verdict in log"; exit 1)

$(SIM): $(SRCS) sim.f
	verilator --binary --timing --assert -j 0 -f sim.f --top-module icache_tb

clean:
	rm -rf obj_dir sim.log

/* tests/icache_tb.sv */
`timescale 1ns/100ps

module icache_tb;
  import icache_pkg::*;

  localparam int WAYS = 4;
  localparam int SETS = 64;
  localparam int MEM_CREDITS = 2;
  localparam int IDX_BITS = $clog2(SETS);
  // two sweeps plus a budget per fetch or fill
  localparam int NUM_OPS = 50;
  localparam int OP_BUDGET = 30;
  localparam int MAX_CYCLES = 2 * (SETS + 20) + NUM_OPS * OP_BUDGET;

  logic clk, rst, fetch_valid, fetch_ready, resp_valid, mem_req_valid, mem_credit;
  logic fill_valid, evict_valid, probe_valid, probe_hit, invalidate, tag_err;
  addr_t fetch_addr;
  fetch_resp_t resp;
  line_addr_t mem_req_addr, evict_addr, probe_addr;
  fill_t fill;

  // reference model state
  logic m_valid [WAYS][SETS];
  line_addr_t m_addr [WAYS][SETS];
  line_t m_data [WAYS][SETS];
  logic [WAYS-1:0] m_nru [SETS];

  logic [31:0] lfsr = 32'hfbfd_eb0d;
  int cycle = 0;
  int errors = 0;
  int checks = 0;
  int hits_seen = 0;
  int misses_seen = 0;
  int evicts_seen = 0;
  int reqs_seen = 0;
  int outstanding = 0;
  int owed = 0;
  logic withhold = 1'b0;
  logic probe_on = 1'b0;
  string test_name = "reset";
  line_addr_t req_addr_q [$];
  int req_due_q [$];
  fill_t direct_q [$];
  line_addr_t touched [$];

  // compare pipeline
  logic acc_prev, fill_prev, probe_prev, inv_prev, lk_pend, nru_pend, wr_pend;
  line_addr_t acc_addr, probe_prev_addr, lk_addr;
  fill_t fill_prev_data, wr_fill;
  fetch_resp_t lk_exp;
  int nru_way, wr_way;

  icache_top #(.WAYS(WAYS), .SETS(SETS), .MEM_CREDITS(MEM_CREDITS)) icache_top_inst (
    .clk, .rst, .fetch_valid, .fetch_addr, .fetch_ready, .resp_valid, .resp,
    .mem_req_valid, .mem_req_addr, .mem_credit, .fill_valid, .fill,
    .evict_valid, .evict_addr, .probe_valid, .probe_addr, .probe_hit,
    .invalidate, .tag_err
  );

  bind icache_top icache_asserts asserts_inst (
    .clk, .rst, .accept, .resp_valid, .mem_req_valid, .no_credit(credits == '0),
    .invalidate, .fetch_ready, .tag_err
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[126:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic line_addr_t rand_line();
    logic [127:0] r;
    r = rand_bits(LINE_ADDR_BITS);
    return r[LINE_ADDR_BITS-1:0];
  endfunction

  function automatic int set_of(input line_addr_t a);
    return int'(a[IDX_BITS-1:0]);
  endfunction

  function automatic int find_way(input line_addr_t a);
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[w][set_of(a)] && m_addr[w][set_of(a)] == a) return w;
    end
    return -1;
  endfunction

  // expected hit flag and line for a lookup
  function automatic fetch_resp_t expected_resp(input line_addr_t a);
    fetch_resp_t r;
    int w;
    w = find_way(a);
    r.hit = (w >= 0);
    r.data = (w >= 0) ? m_data[w][set_of(a)] : '0;
    return r;
  endfunction

  // resident copy, then first empty way, then first clear NRU bit
  function automatic int pick_victim(input line_addr_t a);
    int s;
    s = set_of(a);
    if (find_way(a) >= 0) return find_way(a);
    for (int w = 0; w < WAYS; w++) begin
      if (!m_valid[w][s]) return w;
    end
    for (int w = 0; w < WAYS; w++) begin
      if (!m_nru[s][w]) return w;
    end
    return 0;
  endfunction

  function automatic logic [WAYS-1:0] nru_update(input logic [WAYS-1:0] bits, input int w);
    logic [WAYS-1:0] r;
    r = bits;
    r[w] = 1'b1;
    if (&r) begin
      r = '0;
      r[w] = 1'b1;
    end
    return r;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < SETS; s++) begin
      m_nru[s] = '0;
      for (int w = 0; w < WAYS; w++) begin
        m_valid[w][s] = 1'b0;
      end
    end
  endtask

  task automatic report_mismatch(input string what, input logic [127:0] exp,
                                 input logic [127:0] act);
    errors++;
    $display("** Error %s: %s expected %0h, actual %0h", test_name, what, exp, act);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : watchdog
    while (cycle < MAX_CYCLES) begin
      @(posedge clk);
      cycle++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  // memory answers requests in order, the credit follows the fill
  initial begin : memory
    fill_valid = 1'b0;
    fill = '0;
    mem_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      mem_credit = 1'b0;
      fill_valid = 1'b0;
      if (owed > 0 && !withhold) begin
        mem_credit = 1'b1;
        owed--;
      end
      if (direct_q.size() > 0) begin
        fill = direct_q.pop_front();
        fill_valid = 1'b1;
      end else if (req_addr_q.size() > 0 && req_due_q[0] <= cycle) begin
        fill.addr = req_addr_q.pop_front();
        void'(req_due_q.pop_front());
        fill.data = rand_bits(LINE_BITS);
        fill_valid = 1'b1;
        owed++;
      end
    end
  end

  // even probes hit touched lines, odd ones a flipped tag
  initial begin : probe_driver
    int n;
    n = 0;
    probe_valid = 1'b0;
    probe_addr = '0;
    forever begin
      @(posedge clk);
      #1;
      probe_valid = probe_on && touched.size() > 0;
      if (probe_valid) begin
        probe_addr = touched[(n / 2) % touched.size()];
        if (n[0]) begin
          probe_addr[LINE_ADDR_BITS-1] = ~probe_addr[LINE_ADDR_BITS-1];
        end
        n++;
      end
    end
  end

  initial begin : compare
    acc_prev = 0;
    forever begin
      @(negedge clk);
      if (rst) begin
        clear_model();
        {acc_prev, fill_prev, probe_prev, inv_prev, lk_pend, nru_pend, wr_pend} = '0;
        continue;
      end
      checks++;
      // effects of the last rising edge
      if (nru_pend) begin
        m_nru[set_of(lk_addr)] = nru_update(m_nru[set_of(lk_addr)], nru_way);
        nru_pend = 1'b0;
      end
      if (wr_pend) begin
        m_valid[wr_way][set_of(wr_fill.addr)] = 1'b1;
        m_addr[wr_way][set_of(wr_fill.addr)] = wr_fill.addr;
        m_data[wr_way][set_of(wr_fill.addr)] = wr_fill.data;
        m_nru[set_of(wr_fill.addr)] = nru_update(m_nru[set_of(wr_fill.addr)], wr_way);
        wr_pend = 1'b0;
      end
      if (inv_prev) clear_model();
      if (probe_hit !== (probe_prev && find_way(probe_prev_addr) >= 0)) begin
        report_mismatch("probe_hit", 128'(probe_prev && find_way(probe_prev_addr) >= 0),
                        128'(probe_hit));
      end
      if (resp_valid !== lk_pend) report_mismatch("resp_valid", 128'(lk_pend), 128'(resp_valid));
      if (mem_req_valid !== (lk_pend && !lk_exp.hit)) begin
        report_mismatch("mem_req_valid", 128'(lk_pend && !lk_exp.hit), 128'(mem_req_valid));
      end
      if (resp_valid === 1'b1) begin
        if (resp.hit === 1'b1) begin
          hits_seen++;
        end else begin
          misses_seen++;
        end
      end
      if (lk_pend) begin
        if (resp.hit !== lk_exp.hit) begin
          report_mismatch("resp.hit", 128'(lk_exp.hit), 128'(resp.hit));
        end
        if (lk_exp.hit && resp.data !== lk_exp.data) begin
          report_mismatch("resp.data", lk_exp.data, resp.data);
        end
        if (!lk_exp.hit && mem_req_addr !== lk_addr) begin
          report_mismatch("mem_req_addr", 128'(lk_addr), 128'(mem_req_addr));
        end
        lk_pend = 1'b0;
      end
      if (mem_req_valid) begin
        req_addr_q.push_back(mem_req_addr);
        req_due_q.push_back(cycle + 3 + reqs_seen % 3);
        reqs_seen++;
      end
      outstanding = outstanding + int'(mem_req_valid) - int'(mem_credit);
      if (outstanding > MEM_CREDITS) begin
        errors++;
        $display("%s: %0d memory requests outstanding", test_name, outstanding);
      end
      if (tag_err !== 1'b0) report_mismatch("tag_err", 128'(0), 128'(tag_err));
      // fill read its set during this cycle
      if (fill_prev) begin
        wr_way = pick_victim(fill_prev_data.addr);
        wr_fill = fill_prev_data;
        wr_pend = 1'b1;
        if (evict_valid !== (find_way(wr_fill.addr) < 0
                             && m_valid[wr_way][set_of(wr_fill.addr)])) begin
          report_mismatch("evict_valid", 128'(!evict_valid), 128'(evict_valid));
        end
        if (evict_valid && evict_addr !== m_addr[wr_way][set_of(wr_fill.addr)]) begin
          report_mismatch("evict_addr", 128'(m_addr[wr_way][set_of(wr_fill.addr)]),
                          128'(evict_addr));
        end
      end else if (evict_valid !== 1'b0) begin
        report_mismatch("evict_valid", 128'(0), 128'(evict_valid));
      end
      if (evict_valid) evicts_seen++;
      if (acc_prev) begin
        lk_addr = acc_addr;
        lk_exp = expected_resp(acc_addr);
        lk_pend = 1'b1;
        nru_pend = lk_exp.hit;
        nru_way = find_way(acc_addr);
      end
      acc_prev = fetch_valid && fetch_ready;
      acc_addr = fetch_addr[ADDR_BITS-1:LINE_BYTES_LOG];
      fill_prev = fill_valid;
      fill_prev_data = fill;
      probe_prev = probe_valid;
      probe_prev_addr = probe_addr;
      inv_prev = invalidate;
    end
  end

  task automatic do_fetch(input line_addr_t line, input logic [3:0] off);
    touched.push_back(line);
    fetch_valid = 1'b1;
    fetch_addr = {line, off};
    @(negedge clk);
    while (!fetch_ready) @(negedge clk);
    @(posedge clk);
    #1;
    fetch_valid = 1'b0;
  endtask

  task automatic wait_quiet();
    int calm;
    calm = 0;
    while (calm < 6) begin
      @(negedge clk);
      if (req_addr_q.size() == 0 && direct_q.size() == 0 && owed == 0 && !fill_valid
          && !resp_valid && !fetch_valid) calm++;
      else calm = 0;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_sweep();
    int low;
    low = 0;
    @(negedge clk);
    while (!fetch_ready) begin
      low++;
      @(negedge clk);
    end
    if (low != SETS) report_mismatch("sweep cycles", 128'(SETS), 128'(low));
    @(posedge clk);
    #1;
  endtask

  task automatic count_check(input string what, input int exp, input int act);
    if (exp != act) report_mismatch(what, 128'(exp), 128'(act));
  endtask

  initial begin : stimulus
    line_addr_t lines [6];
    line_addr_t resident [$];
    fill_t f;
    logic [127:0] r;
    int base;
    rst = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr = '0;
    invalidate = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    test_name = "sweep after reset";
    check_sweep();

    test_name = "cold misses";
    for (int i = 0; i < 4; i++) lines[i] = rand_line();
    for (int i = 0; i < 4; i++) do_fetch(lines[i], 4'h0);
    wait_quiet();
    count_check("cold misses", 4, misses_seen);

    test_name = "hits after fill";
    base = hits_seen;
    for (int i = 0; i < 4; i++) begin
      r = rand_bits(4);
      do_fetch(lines[i], r[3:0]);
    end
    do_fetch(rand_line(), 4'h8);
    wait_quiet();
    count_check("hits", 4, hits_seen - base);

    test_name = "set conflicts";
    probe_on = 1'b1;
    base = evicts_seen;
    r = rand_bits(IDX_BITS);
    for (int i = 0; i < 6; i++) begin
      lines[i] = rand_line();
      lines[i][IDX_BITS-1:0] = r[IDX_BITS-1:0];
      touched.push_back(lines[i]);
    end
    @(negedge clk);
    for (int i = 0; i < 5; i++) begin
      f.addr = lines[i];
      f.data = rand_bits(LINE_BITS);
      direct_q.push_back(f);
    end
    wait_quiet();
    do_fetch(lines[3], 4'h4);
    do_fetch(lines[4], 4'hc);
    wait_quiet();
    @(negedge clk);
    f.addr = lines[5];
    f.data = rand_bits(LINE_BITS);
    direct_q.push_back(f);
    // re-fill of a resident line
    f.addr = lines[4];
    f.data = rand_bits(LINE_BITS);
    direct_q.push_back(f);
    wait_quiet();
    do_fetch(lines[4], 4'h0);
    wait_quiet();
    if (evicts_seen - base < 2) begin
      errors++;
      $display("%s: full set produced only %0d evictions", test_name, evicts_seen - base);
    end

    test_name = "credit back-pressure";
    withhold = 1'b1;
    base = reqs_seen;
    fork
      begin
        for (int i = 0; i < 4; i++) do_fetch(rand_line(), 4'h0);
      end
      begin
        wait (reqs_seen >= base + MEM_CREDITS);
        repeat (6) @(negedge clk);
        if (fetch_ready !== 1'b0) begin
          errors++;
          $display("%s: fetch_ready high with all credits in use", test_name);
        end
        count_check("outstanding", MEM_CREDITS, outstanding);
        withhold = 1'b0;
      end
    join
    wait_quiet();
    count_check("requests", 4, reqs_seen - base);

    test_name = "invalidate";
    // every line the model holds before the sweep
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        if (m_valid[w][s]) resident.push_back(m_addr[w][s]);
      end
    end
    invalidate = 1'b1;
    @(posedge clk);
    #1;
    invalidate = 1'b0;
    check_sweep();
    base = misses_seen;
    foreach (resident[i]) do_fetch(resident[i], 4'h0);
    wait_quiet();
    count_check("misses after invalidate", resident.size(), misses_seen - base);
    probe_on = 1'b0;
    repeat (4) @(posedge clk);

    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             icache_top_inst.asserts_inst.fail_count);
    if (errors == 0 && icache_top_inst.asserts_inst.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tests/icache_asserts.sv */
`timescale 1ns/100ps

module icache_asserts (
  input logic clk,
  input logic rst,
  input logic accept,
  input logic resp_valid,
  input logic mem_req_valid,
  input logic no_credit,
  input logic invalidate,
  input logic fetch_ready,
  input logic tag_err
);

  int fail_count = 0;

  // a request must always have a credit behind it
  credit_check: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid |-> !no_credit)
    else begin
      $error("memory request issued with no credit left");
      fail_count++;
    end

  // response two cycles after each accepted fetch, and never otherwise
  resp_timing: assert property (@(posedge clk) disable iff (rst)
    resp_valid == $past(accept, 2))
    else begin
      $error("response not two cycles after its fetch");
      fail_count++;
    end

  // a new sweep closes the fetch port right away
  sweep_blocks_fetch: assert property (@(posedge clk) disable iff (rst)
    invalidate |=> !fetch_ready)
    else begin
      $error("fetch_ready high at the start of the clearing sweep");
      fail_count++;
    end

  no_tag_err: assert property (@(posedge clk) disable iff (rst) !tag_err)
    else begin
      $error("line found in more than one way");
      fail_count++;
    end

endmodule

/* source/icache_top.sv */
`timescale 1ns/100ps

module icache_top #(
  parameter int WAYS = 4,
  parameter int SETS = 64,
  parameter int MEM_CREDITS = 2
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_valid,
  input  icache_pkg::addr_t       fetch_addr,
  output logic                    fetch_ready,
  output logic                    resp_valid,
  output icache_pkg::fetch_resp_t resp,
  output logic                    mem_req_valid,
  output icache_pkg::line_addr_t  mem_req_addr,
  input  logic                    mem_credit,
  input  logic                    fill_valid,
  input  icache_pkg::fill_t       fill,
  output logic                    evict_valid,
  output icache_pkg::line_addr_t  evict_addr,
  input  logic                    probe_valid,
  input  icache_pkg::line_addr_t  probe_addr,
  output logic                    probe_hit,
  input  logic                    invalidate,
  output logic                    tag_err
);
  import icache_pkg::*;

  localparam int CREDIT_BITS = $clog2(MEM_CREDITS + 1);

  typedef logic [CREDIT_BITS-1:0] credit_t;

  credit_t credits;
  int in_flight;
  logic accept;
  line_addr_t fetch_line;
  logic s1_valid;
  line_addr_t s1_addr;
  logic fill_seen_q;
  logic sweeping;
  logic look_hit;
  logic multi_hit;
  line_t look_data;

  assign fetch_line = fetch_addr[ADDR_BITS-1:LINE_BYTES_LOG];

  // every lookup in flight may still turn into a miss
  assign in_flight = int'(s1_valid) + int'(resp_valid);

  // keep lookups off the NRU bits while a fill owns them
  assign fetch_ready = !sweeping && !fill_valid && !fill_seen_q
                       && (int'(credits) > in_flight);
  assign accept = fetch_valid && fetch_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= credit_t'(MEM_CREDITS);
    end else begin
      credits <= credits - credit_t'(mem_req_valid) + credit_t'(mem_credit);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid      <= 1'b0;
      resp_valid    <= 1'b0;
      mem_req_valid <= 1'b0;
      fill_seen_q   <= 1'b0;
      tag_err       <= 1'b0;
    end else begin
      s1_valid      <= accept;
      resp_valid    <= s1_valid;
      mem_req_valid <= s1_valid && !look_hit;
      fill_seen_q   <= fill_valid;
      tag_err       <= s1_valid && multi_hit;
    end
  end

  // payload of both stages
  always_ff @(posedge clk) begin
    if (accept) begin
      s1_addr <= fetch_line;
    end
    if (s1_valid) begin
      resp.hit     <= look_hit;
      resp.data    <= look_data;
      mem_req_addr <= s1_addr;
    end
  end

  icache_array #(.WAYS(WAYS), .SETS(SETS)) array_inst (
    .clk, .rst, .invalidate,
    .look_en(accept), .look_addr(fetch_line), .look_hit, .look_data,
    .probe_en(probe_valid), .probe_addr, .probe_hit,
    .fill_en(fill_valid), .fill,
    .evict_valid, .evict_addr,
    .sweeping, .multi_hit
  );

endmodule

/* source/icache_array.sv */
`timescale 1ns/100ps

module icache_array #(
  parameter int WAYS = 4,
  parameter int SETS = 64
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   invalidate,
  input  logic                   look_en,
  input  icache_pkg::line_addr_t look_addr,
  output logic                   look_hit,
  output icache_pkg::line_t      look_data,
  input  logic                   probe_en,
  input  icache_pkg::line_addr_t probe_addr,
  output logic                   probe_hit,
  input  logic                   fill_en,
  input  icache_pkg::fill_t      fill,
  output logic                   evict_valid,
  output icache_pkg::line_addr_t evict_addr,
  output logic                   sweeping,
  output logic                   multi_hit
);
  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(SETS);

  typedef logic [IDX_BITS-1:0] index_t;
  typedef logic [WAYS-1:0] way_vec_t;

  way_vec_t nru [SETS];
  index_t sweep_idx;
  logic look_q;
  index_t look_idx_q;
  logic fill_q_valid;
  fill_t fill_q;
  index_t fill_idx;
  logic fill_write;
  logic way_look_en;
  line_addr_t way_look_addr;
  line_addr_t wr_addr;
  way_vec_t wr_en_w;
  way_vec_t hit_w;
  way_vec_t valid_w;
  way_vec_t probe_w;
  way_vec_t victim_oh;
  line_addr_t stored_w [WAYS];
  line_t chain [WAYS+1];

  // lowest set bit only
  function automatic way_vec_t first_one(input way_vec_t v);
    return v & (~v + 1'b1);
  endfunction

  // mark a way used, start over once the whole set is marked
  function automatic way_vec_t nru_mark(input way_vec_t bits, input way_vec_t sel);
    way_vec_t r;
    r = bits | sel;
    return (&r) ? sel : r;
  endfunction

  always_ff @(posedge clk) begin
    if (rst || invalidate) begin
      sweeping  <= 1'b1;
      sweep_idx <= '0;
    end else if (sweeping) begin
      sweep_idx <= sweep_idx + 1'b1;
      if (sweep_idx == index_t'(SETS - 1)) begin
        sweeping <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      look_q       <= 1'b0;
      fill_q_valid <= 1'b0;
    end else begin
      look_q       <= look_en && !fill_en;
      fill_q_valid <= fill_en;
    end
  end

  always_ff @(posedge clk) begin
    if (look_en) begin
      look_idx_q <= look_addr[IDX_BITS-1:0];
    end
    if (fill_en) begin
      fill_q <= fill;
    end
  end

  // a fill borrows the lookup port to read its set
  assign way_look_en = look_en || fill_en;
  assign way_look_addr = fill_en ? fill.addr : look_addr;

  assign fill_idx = fill_q.addr[IDX_BITS-1:0];
  assign fill_write = fill_q_valid && !sweeping;

  // resident copy first, then an empty way, then NRU
  always_comb begin
    if (|hit_w) begin
      victim_oh = first_one(hit_w);
    end else if (!(&valid_w)) begin
      victim_oh = first_one(~valid_w);
    end else begin
      victim_oh = first_one(~nru[fill_idx]);
    end
  end

  assign wr_addr = sweeping ? line_addr_t'(sweep_idx) : fill_q.addr;
  assign wr_en_w = sweeping ? '1 : (fill_write ? victim_oh : '0);

  always_ff @(posedge clk) begin
    if (sweeping) begin
      nru[sweep_idx] <= '0;
    end else if (fill_write) begin
      nru[fill_idx] <= nru_mark(nru[fill_idx], victim_oh);
    end else if (look_q && look_hit) begin
      nru[look_idx_q] <= nru_mark(nru[look_idx_q], hit_w);
    end
  end

  assign chain[0] = '0;

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    icache_way #(.SETS(SETS)) way_inst (
      .clk, .rst,
      .look_en(way_look_en), .look_addr(way_look_addr),
      .probe_en, .probe_addr, .probe_hit(probe_w[w]),
      .wr_en(wr_en_w[w]), .wr_addr, .wr_data(fill_q.data), .wr_valid(!sweeping),
      .data_in(chain[w]), .data_out(chain[w+1]),
      .hit(hit_w[w]), .valid(valid_w[w]), .stored_addr(stored_w[w])
    );
  end

  always_comb begin
    evict_addr = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (victim_oh[w]) begin
        evict_addr = stored_w[w];
      end
    end
  end

  // a miss into a full set pushes out a valid line
  assign evict_valid = fill_write && !(|hit_w) && (&valid_w);

  assign look_hit = |hit_w;
  assign look_data = chain[WAYS];
  assign multi_hit = (hit_w & (hit_w - 1'b1)) != '0;
  assign probe_hit = (|probe_w) && !sweeping;

endmodule

/* source/icache_way.sv */
`timescale 1ns/100ps

module icache_way #(
  parameter int SETS = 64
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   look_en,
  input  icache_pkg::line_addr_t look_addr,
  input  logic                   probe_en,
  input  icache_pkg::line_addr_t probe_addr,
  output logic                   probe_hit,
  input  logic                   wr_en,
  input  icache_pkg::line_addr_t wr_addr,
  input  icache_pkg::line_t      wr_data,
  input  logic                   wr_valid,
  input  icache_pkg::line_t      data_in,
  output icache_pkg::line_t      data_out,
  output logic                   hit,
  output logic                   valid,
  output icache_pkg::line_addr_t stored_addr
);
  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(SETS);

  logic [IDX_BITS-1:0] look_idx;
  logic [IDX_BITS-1:0] look_idx_q;
  logic [IDX_BITS-1:0] probe_idx;
  logic [IDX_BITS-1:0] wr_idx;
  tag_t look_tag;
  tag_t probe_tag;
  tag_t wr_tag;
  tag_t stored_tag;
  line_t line;

  // index from the low line address bits, tag from above the widest index
  assign look_idx = look_addr[IDX_BITS-1:0];
  assign probe_idx = probe_addr[IDX_BITS-1:0];
  assign wr_idx = wr_addr[IDX_BITS-1:0];
  assign look_tag = look_addr[LINE_ADDR_BITS-1 -: TAG_BITS];
  assign probe_tag = probe_addr[LINE_ADDR_BITS-1 -: TAG_BITS];
  assign wr_tag = wr_addr[LINE_ADDR_BITS-1 -: TAG_BITS];

  icache_tag_ram #(.SETS(SETS)) tag_inst (
    .clk, .rst,
    .rd_en(look_en), .rd_index(look_idx), .rd_tag(look_tag),
    .rd_hit(hit), .rd_valid(valid), .rd_stored_tag(stored_tag),
    .probe_en, .probe_index(probe_idx), .probe_tag, .probe_hit,
    .wr_en, .wr_index(wr_idx), .wr_tag, .wr_valid
  );

  // sweep only clears tags, line data is left alone
  icache_data_ram #(.SETS(SETS)) data_inst (
    .clk, .rst,
    .rd_en(look_en), .rd_index(look_idx), .rd_data(line),
    .wr_en(wr_en && wr_valid), .wr_index(wr_idx), .wr_data
  );

  // set of the current read, for rebuilding the resident line address
  always_ff @(posedge clk) begin
    if (look_en) begin
      look_idx_q <= look_idx;
    end
  end

  assign stored_addr = {stored_tag, INDEX_BITS_MAX'(look_idx_q)};

  // or chain through the ways
  assign data_out = data_in | ({LINE_BITS{hit}} & line);

endmodule

/* source/icache_tag_ram.sv */
`timescale 1ns/100ps

module icache_tag_ram #(
  parameter int SETS = 64
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rd_en,
  input  logic [$clog2(SETS)-1:0] rd_index,
  input  icache_pkg::tag_t        rd_tag,
  output logic                    rd_hit,
  output logic                    rd_valid,
  output icache_pkg::tag_t        rd_stored_tag,
  input  logic                    probe_en,
  input  logic [$clog2(SETS)-1:0] probe_index,
  input  icache_pkg::tag_t        probe_tag,
  output logic                    probe_hit,
  input  logic                    wr_en,
  input  logic [$clog2(SETS)-1:0] wr_index,
  input  icache_pkg::tag_t        wr_tag,
  input  logic                    wr_valid
);
  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(SETS);

  typedef struct packed {
    logic valid;
    tag_t tag;
  } entry_t;

  entry_t mem [SETS];
  logic [IDX_BITS-1:0] rd_index_q;
  logic [IDX_BITS-1:0] probe_index_q;
  tag_t rd_tag_q;
  tag_t probe_tag_q;
  logic probe_en_q;
  entry_t rd_entry;
  entry_t probe_entry;

  // sweep clears entries by writing valid low
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= '{valid: wr_valid, tag: wr_tag};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_index_q    <= '0;
      probe_index_q <= '0;
      probe_en_q    <= 1'b0;
    end else begin
      probe_en_q <= probe_en;
      if (rd_en) begin
        rd_index_q <= rd_index;
      end
      if (probe_en) begin
        probe_index_q <= probe_index;
      end
    end
  end

  // compare tags travel with the index
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_tag_q <= rd_tag;
    end
    if (probe_en) begin
      probe_tag_q <= probe_tag;
    end
  end

  assign rd_entry = mem[rd_index_q];
  assign probe_entry = mem[probe_index_q];

  assign rd_valid = rd_entry.valid;
  assign rd_stored_tag = rd_entry.tag;
  assign rd_hit = rd_entry.valid && (rd_entry.tag == rd_tag_q);
  assign probe_hit = probe_en_q && probe_entry.valid && (probe_entry.tag == probe_tag_q);

endmodule

/* source/icache_data_ram.sv */
`timescale 1ns/100ps

module icache_data_ram #(
  parameter int SETS = 64
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rd_en,
  input  logic [$clog2(SETS)-1:0] rd_index,
  output icache_pkg::line_t       rd_data,
  input  logic                    wr_en,
  input  logic [$clog2(SETS)-1:0] wr_index,
  input  icache_pkg::line_t       wr_data
);
  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(SETS);

  line_t mem [SETS];
  logic [IDX_BITS-1:0] rd_index_q;

  // address is held until the next read request
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_index_q <= '0;
    end else if (rd_en) begin
      rd_index_q <= rd_index;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  assign rd_data = mem[rd_index_q];

endmodule

/* source/icache_pkg.sv */
package icache_pkg;

  // address geometry
  localparam int ADDR_BITS = 32;
  localparam int LINE_BYTES_LOG = 4;
  localparam int LINE_BITS = 8 << LINE_BYTES_LOG;
  localparam int LINE_ADDR_BITS = ADDR_BITS - LINE_BYTES_LOG;

  // widest set index, the tag sits above it
  localparam int INDEX_BITS_MAX = 6;
  localparam int TAG_BITS = ADDR_BITS - LINE_BYTES_LOG - INDEX_BITS_MAX;

  // byte address of a fetch
  typedef logic [ADDR_BITS-1:0] addr_t;

  // one cache line of instruction bytes
  typedef logic [LINE_BITS-1:0] line_t;

  typedef logic [TAG_BITS-1:0] tag_t;

  // byte address without the line offset
  typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

  // line returned by memory
  typedef struct packed {
    line_addr_t addr;
    line_t      data;
  } fill_t;

  // answer to the fetch unit
  typedef struct packed {
    logic  hit;
    line_t data;
  } fetch_resp_t;

endpackage
